//--- source/pcore_pkg.sv
`default_nettype none

package pcore_pkg;

    // Datapath and register file geometry
    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned CSR_ADDR_W = 12;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // Supported machine-mode CSRs
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MINSTRET = 12'hB02;

    // Source of the value written back to rd with encodings 5 to 7 illegal
    typedef enum logic [2:0] {
        RD_WRB_ALU    = 3'd0,
        RD_WRB_INC_PC = 3'd1,
        RD_WRB_DMEM   = 3'd2,
        RD_WRB_CSR    = 3'd3,
        RD_WRB_M_ALU  = 3'd4
    } rd_wrb_sel_e;

    typedef enum logic [2:0] {
        LD_NONE = 3'd0,
        LD_B    = 3'd1,
        LD_H    = 3'd2,
        LD_W    = 3'd3,
        LD_BU   = 3'd4,
        LD_HU   = 3'd5
    } ld_op_e;

    // A write returns the old CSR value before updating it
    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_READ  = 2'd1,
        CSR_WRITE = 2'd2
    } csr_op_e;

    // Execute to load/store stage
    typedef struct packed {
        word_t     alu_result;
        word_t     alu_m_result;
        word_t     pc_next;
        word_t     csr_wdata;
        reg_addr_t rd_addr;
    } exe2lsu_data_s;

    typedef struct packed {
        rd_wrb_sel_e rd_wrb_sel;
        logic        rd_wr_req;
        ld_op_e      ld_op;
        csr_op_e     csr_op;
        csr_addr_t   csr_addr;
    } exe2lsu_ctrl_s;

    // Load/store stage to writeback
    typedef struct packed {
        word_t     alu_result;
        word_t     alu_m_result;
        word_t     pc_next;
        word_t     r_data;
        reg_addr_t rd_addr;
    } lsu2wrb_data_s;

    typedef struct packed {
        rd_wrb_sel_e rd_wrb_sel;
        logic        rd_wr_req;
    } lsu2wrb_ctrl_s;

    typedef struct packed {
        word_t csr_rdata;
    } csr2wrb_data_s;

    // Writeback feedback towards decode and the forwarding unit
    typedef struct packed {
        word_t     rd_data;
        reg_addr_t rd_addr;
        logic      rd_wr_req;
    } wrb2id_fb_s;

    typedef struct packed {
        reg_addr_t rd_addr;
        logic      rd_wr_req;
    } wrb2fwd_s;

endpackage : pcore_pkg

`default_nettype wire

//--- source/lsu_stage.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_stage (
    input  wire                      clk,
    input  wire                      arst_n_i,

    // From execute and the data memory
    input  wire pcore_pkg::exe2lsu_data_s exe2lsu_data_i,
    input  wire pcore_pkg::exe2lsu_ctrl_s exe2lsu_ctrl_i,
    input  wire pcore_pkg::word_t         dmem_rdata_i,

    // To writeback
    output pcore_pkg::lsu2wrb_data_s      lsu2wrb_data_o,
    output pcore_pkg::lsu2wrb_ctrl_s      lsu2wrb_ctrl_o
);
    import pcore_pkg::*;

    logic [1:0] byte_off;
    word_t      rdata_shift;
    word_t      ld_data;

    // Low address bits pick the byte lane within the memory word
    assign byte_off    = exe2lsu_data_i.alu_result[1:0];
    assign rdata_shift = dmem_rdata_i >> {byte_off, 3'b000};

    // Sign or zero extension of the selected lane
    always_comb begin
        case (exe2lsu_ctrl_i.ld_op)
            LD_B:    ld_data = {{(XLEN-8){rdata_shift[7]}}, rdata_shift[7:0]};
            LD_H:    ld_data = {{(XLEN-16){rdata_shift[15]}}, rdata_shift[15:0]};
            LD_W:    ld_data = rdata_shift;
            LD_BU:   ld_data = {{(XLEN-8){1'b0}}, rdata_shift[7:0]};
            LD_HU:   ld_data = {{(XLEN-16){1'b0}}, rdata_shift[15:0]};
            default: ld_data = '0;
        endcase
    end

    // Stage register that accepts one instruction every cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lsu2wrb_data_o <= '0;
            lsu2wrb_ctrl_o <= '0;
        end else begin
            lsu2wrb_data_o.alu_result   <= exe2lsu_data_i.alu_result;
            lsu2wrb_data_o.alu_m_result <= exe2lsu_data_i.alu_m_result;
            lsu2wrb_data_o.pc_next      <= exe2lsu_data_i.pc_next;
            lsu2wrb_data_o.r_data       <= ld_data;
            lsu2wrb_data_o.rd_addr      <= exe2lsu_data_i.rd_addr;
            lsu2wrb_ctrl_o.rd_wrb_sel   <= exe2lsu_ctrl_i.rd_wrb_sel;
            lsu2wrb_ctrl_o.rd_wr_req    <= exe2lsu_ctrl_i.rd_wr_req;
        end
    end

    // Execute never presents a misaligned load
    a_ld_half_aligned: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (exe2lsu_ctrl_i.ld_op inside {LD_H, LD_HU}) |-> !exe2lsu_data_i.alu_result[0]
    );

    a_ld_word_aligned: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (exe2lsu_ctrl_i.ld_op == LD_W) |-> (exe2lsu_data_i.alu_result[1:0] == 2'b00)
    );

    // Memory data in writeback only makes sense for a real load
    a_dmem_sel_needs_load: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (exe2lsu_ctrl_i.rd_wrb_sel == RD_WRB_DMEM)
            |-> (exe2lsu_ctrl_i.ld_op inside {LD_B, LD_H, LD_W, LD_BU, LD_HU})
    );

endmodule : lsu_stage

`default_nettype wire

//--- source/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  wire                       clk,
    input  wire                       arst_n_i,

    // CSR request from execute sampled with the load/store stage
    input  wire pcore_pkg::csr_op_e   csr_op_i,
    input  wire pcore_pkg::csr_addr_t csr_addr_i,
    input  wire pcore_pkg::word_t     csr_wdata_i,

    // Writeback feedback used to count retired register writes
    input  wire pcore_pkg::wrb2id_fb_s retire_i,

    // Old CSR value aligned to the writeback stage
    output pcore_pkg::csr2wrb_data_s   csr2wrb_data_o
);
    import pcore_pkg::*;

    word_t mscratch_q;
    word_t minstret_q;
    word_t csr_rdata_d;
    logic  csr_access;
    logic  retire;

    assign csr_access = (csr_op_i == CSR_READ) || (csr_op_i == CSR_WRITE);

    // Only writes to a real register count as retired
    assign retire = retire_i.rd_wr_req && (retire_i.rd_addr != '0);

    // Unknown addresses read as zero
    always_comb begin
        case (csr_addr_i)
            CSR_MSCRATCH: csr_rdata_d = mscratch_q;
            CSR_MINSTRET: csr_rdata_d = minstret_q;
            default:      csr_rdata_d = '0;
        endcase
    end

    // Read value captured before the write lands at the same edge
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            csr2wrb_data_o <= '0;
        end else begin
            csr2wrb_data_o.csr_rdata <= csr_access ? csr_rdata_d : '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mscratch_q <= '0;
        end else if ((csr_op_i == CSR_WRITE) && (csr_addr_i == CSR_MSCRATCH)) begin
            mscratch_q <= csr_wdata_i;
        end
    end

    // minstret is read-only from software
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            minstret_q <= '0;
        end else if (retire) begin
            minstret_q <= minstret_q + 1'b1;
        end
    end

    a_no_minstret_write: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !((csr_op_i == CSR_WRITE) && (csr_addr_i == CSR_MINSTRET))
    );

endmodule : csr_unit

`default_nettype wire

//--- source/writeback.sv
`timescale 1ns/1ps
`default_nettype none

module writeback (
    input  wire                           clk,
    input  wire                           arst_n_i,

    // From the load/store stage and the CSR unit
    input  wire pcore_pkg::lsu2wrb_data_s lsu2wrb_data_i,
    input  wire pcore_pkg::lsu2wrb_ctrl_s lsu2wrb_ctrl_i,
    input  wire pcore_pkg::csr2wrb_data_s csr2wrb_data_i,

    // Feedback to decode and the register file
    output pcore_pkg::wrb2id_fb_s         wrb2id_fb_o,

    // Destination info for operand forwarding
    output pcore_pkg::wrb2fwd_s           wrb2fwd_o
);
    import pcore_pkg::*;

    word_t wrb_rd_data;

    // Result select where illegal encodings give zero
    always_comb begin
        case (lsu2wrb_ctrl_i.rd_wrb_sel)
            RD_WRB_ALU:    wrb_rd_data = lsu2wrb_data_i.alu_result;
            RD_WRB_INC_PC: wrb_rd_data = lsu2wrb_data_i.pc_next;
            RD_WRB_DMEM:   wrb_rd_data = lsu2wrb_data_i.r_data;
            RD_WRB_CSR:    wrb_rd_data = csr2wrb_data_i.csr_rdata;
            RD_WRB_M_ALU:  wrb_rd_data = lsu2wrb_data_i.alu_m_result;
            default:       wrb_rd_data = '0;
        endcase
    end

    assign wrb2id_fb_o.rd_data   = wrb_rd_data;
    assign wrb2id_fb_o.rd_addr   = lsu2wrb_data_i.rd_addr;
    assign wrb2id_fb_o.rd_wr_req = lsu2wrb_ctrl_i.rd_wr_req;

    assign wrb2fwd_o.rd_addr     = lsu2wrb_data_i.rd_addr;
    assign wrb2fwd_o.rd_wr_req   = lsu2wrb_ctrl_i.rd_wr_req;

    // A retiring write must carry a select that execute could have issued
    a_wrb_sel_legal: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        lsu2wrb_ctrl_i.rd_wr_req
            |-> (lsu2wrb_ctrl_i.rd_wrb_sel inside
                 {RD_WRB_ALU, RD_WRB_INC_PC, RD_WRB_DMEM, RD_WRB_CSR, RD_WRB_M_ALU})
    );

endmodule : writeback

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
    parameter int unsigned XLEN_P = pcore_pkg::XLEN
) (
    input  wire                        clk,
    input  wire                        arst_n_i,

    // Write port driven by writeback
    input  wire pcore_pkg::wrb2id_fb_s wrb2id_fb_i,

    // Two combinational read ports
    input  wire pcore_pkg::reg_addr_t  rs1_addr_i,
    input  wire pcore_pkg::reg_addr_t  rs2_addr_i,
    output logic [XLEN_P-1:0]          rs1_rdata_o,
    output logic [XLEN_P-1:0]          rs2_rdata_o
);
    import pcore_pkg::*;

    localparam int unsigned NUM_REGS = 2 ** REG_ADDR_W;

    // x0 has no storage
    logic [XLEN_P-1:0] regs_q [1:NUM_REGS-1];
    logic              wr_en;

    assign wr_en = wrb2id_fb_i.rd_wr_req && (wrb2id_fb_i.rd_addr != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wrb2id_fb_i.rd_addr] <= wrb2id_fb_i.rd_data[XLEN_P-1:0];
        end
    end

    // Stored value only since same-cycle writes are handled by operand_fwd
    always_comb begin
        rs1_rdata_o = '0;
        rs2_rdata_o = '0;
        if (rs1_addr_i != '0) begin
            rs1_rdata_o = regs_q[rs1_addr_i];
        end
        if (rs2_addr_i != '0) begin
            rs2_rdata_o = regs_q[rs2_addr_i];
        end
    end

    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        wrb2id_fb_i.rd_wr_req |-> !$isunknown(wrb2id_fb_i.rd_addr)
    );

endmodule : reg_file

`default_nettype wire

//--- source/operand_fwd.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fwd #(
    parameter int unsigned XLEN_P = pcore_pkg::XLEN
) (
    // Value leaving writeback this cycle
    input  wire [XLEN_P-1:0]          wrb_rd_data_i,
    input  wire pcore_pkg::wrb2fwd_s  wrb2fwd_i,

    // Source operands requested by decode
    input  wire pcore_pkg::reg_addr_t rs1_addr_i,
    input  wire pcore_pkg::reg_addr_t rs2_addr_i,

    // Register file read data
    input  wire [XLEN_P-1:0]          rs1_rdata_i,
    input  wire [XLEN_P-1:0]          rs2_rdata_i,

    // Forwarded operands
    output logic [XLEN_P-1:0]         rs1_data_o,
    output logic [XLEN_P-1:0]         rs2_data_o
);
    import pcore_pkg::*;

    logic rs1_hit;
    logic rs2_hit;

    // A pending write to x0 must never be forwarded
    function automatic logic fwd_hit(
        input reg_addr_t rs_addr,
        input wrb2fwd_s  wrb
    );
        return wrb.rd_wr_req && (wrb.rd_addr != '0) && (wrb.rd_addr == rs_addr);
    endfunction

    assign rs1_hit = fwd_hit(rs1_addr_i, wrb2fwd_i);
    assign rs2_hit = fwd_hit(rs2_addr_i, wrb2fwd_i);

    // Writeback data wins over the stale register file value
    always_comb begin
        rs1_data_o = rs1_rdata_i;
        rs2_data_o = rs2_rdata_i;
        if (rs1_hit) begin
            rs1_data_o = wrb_rd_data_i;
        end
        if (rs2_hit) begin
            rs2_data_o = wrb_rd_data_i;
        end
    end

endmodule : operand_fwd

`default_nettype wire

//--- source/core_backend.sv
`timescale 1ns/1ps
`default_nettype none

module core_backend (
    input  wire                           clk,
    input  wire                           arst_n_i,

    // Execute stage and data memory
    input  wire pcore_pkg::exe2lsu_data_s exe2lsu_data_i,
    input  wire pcore_pkg::exe2lsu_ctrl_s exe2lsu_ctrl_i,
    input  wire pcore_pkg::word_t         dmem_rdata_i,

    // Decode operand reads
    input  wire pcore_pkg::reg_addr_t     rs1_addr_i,
    input  wire pcore_pkg::reg_addr_t     rs2_addr_i,
    output pcore_pkg::word_t              rs1_data_o,
    output pcore_pkg::word_t              rs2_data_o,

    // Writeback feedback to decode
    output pcore_pkg::wrb2id_fb_s         wrb2id_fb_o
);
    import pcore_pkg::*;

    localparam int unsigned XLEN_P = XLEN;

    lsu2wrb_data_s     lsu2wrb_data;
    lsu2wrb_ctrl_s     lsu2wrb_ctrl;
    csr2wrb_data_s     csr2wrb_data;
    wrb2id_fb_s        wrb2id_fb;
    wrb2fwd_s          wrb2fwd;
    logic [XLEN_P-1:0] rs1_rdata;
    logic [XLEN_P-1:0] rs2_rdata;

    lsu_stage u_lsu_stage (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .exe2lsu_data_i (exe2lsu_data_i),
        .exe2lsu_ctrl_i (exe2lsu_ctrl_i),
        .dmem_rdata_i   (dmem_rdata_i),
        .lsu2wrb_data_o (lsu2wrb_data),
        .lsu2wrb_ctrl_o (lsu2wrb_ctrl)
    );

    // Samples at the same edge as the load/store stage register
    csr_unit u_csr_unit (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .csr_op_i       (exe2lsu_ctrl_i.csr_op),
        .csr_addr_i     (exe2lsu_ctrl_i.csr_addr),
        .csr_wdata_i    (exe2lsu_data_i.csr_wdata),
        .retire_i       (wrb2id_fb),
        .csr2wrb_data_o (csr2wrb_data)
    );

    writeback u_writeback (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .lsu2wrb_data_i (lsu2wrb_data),
        .lsu2wrb_ctrl_i (lsu2wrb_ctrl),
        .csr2wrb_data_i (csr2wrb_data),
        .wrb2id_fb_o    (wrb2id_fb),
        .wrb2fwd_o      (wrb2fwd)
    );

    reg_file #(
        .XLEN_P (XLEN_P)
    ) u_reg_file (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .wrb2id_fb_i (wrb2id_fb),
        .rs1_addr_i  (rs1_addr_i),
        .rs2_addr_i  (rs2_addr_i),
        .rs1_rdata_o (rs1_rdata),
        .rs2_rdata_o (rs2_rdata)
    );

    operand_fwd #(
        .XLEN_P (XLEN_P)
    ) u_operand_fwd (
        .wrb_rd_data_i (wrb2id_fb.rd_data),
        .wrb2fwd_i     (wrb2fwd),
        .rs1_addr_i    (rs1_addr_i),
        .rs2_addr_i    (rs2_addr_i),
        .rs1_rdata_i   (rs1_rdata),
        .rs2_rdata_i   (rs2_rdata),
        .rs1_data_o    (rs1_data_o),
        .rs2_data_o    (rs2_data_o)
    );

    assign wrb2id_fb_o = wrb2id_fb;

endmodule : core_backend

`default_nettype wire

//--- tb/tb_core_backend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_backend;
    import pcore_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_RANDOM   = 16;
    localparam int MAX_ROWS   = 64;

    logic          clk;
    logic          arst_n;
    exe2lsu_data_s exe_data;
    exe2lsu_ctrl_s exe_ctrl;
    word_t         dmem_rdata;
    reg_addr_t     rs1_addr;
    reg_addr_t     rs2_addr;
    word_t         rs1_data;
    word_t         rs2_data;
    wrb2id_fb_s    wrb_fb;

    // Stimulus table
    exe2lsu_data_s tbl_data [0:MAX_ROWS-1];
    exe2lsu_ctrl_s tbl_ctrl [0:MAX_ROWS-1];
    word_t         tbl_dmem [0:MAX_ROWS-1];
    reg_addr_t     tbl_rs1  [0:MAX_ROWS-1];
    reg_addr_t     tbl_rs2  [0:MAX_ROWS-1];
    int            n_rows = 0;
    logic          rows_started = 1'b0;

    // Reference model state
    word_t         shadow_regs [0:31];
    word_t         mscratch_m;
    word_t         minstret_m;
    word_t         wb_data;
    reg_addr_t     wb_addr;
    logic          wb_req;

    integer        seed;
    int            n_checks = 0;
    int            n_errors = 0;

    core_backend DUT (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .exe2lsu_data_i (exe_data),
        .exe2lsu_ctrl_i (exe_ctrl),
        .dmem_rdata_i   (dmem_rdata),
        .rs1_addr_i     (rs1_addr),
        .rs2_addr_i     (rs2_addr),
        .rs1_data_o     (rs1_data),
        .rs2_data_o     (rs2_data),
        .wrb2id_fb_o    (wrb_fb)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Watchdog sized from the table length
    initial begin
        wait (rows_started);
        #((n_rows + 10) * CLK_PERIOD);
        $display("Timeout: the run did not complete %0d rows in time", n_rows);
        $display("Errors found");
        $finish;
    end

    // The data bundle is derived from one value so each select shows a distinct word
    task automatic add_row(
        input rd_wrb_sel_e sel, input logic req, input ld_op_e ld, input csr_op_e cop,
        input csr_addr_t caddr, input word_t v, input reg_addr_t rd, input word_t dmem,
        input reg_addr_t rs1, input reg_addr_t rs2
    );
        exe2lsu_data_s d;
        exe2lsu_ctrl_s c;
        d.alu_result   = v;
        d.alu_m_result = {v[15:0], v[31:16]} ^ 32'h5a5a_a5a5;
        d.pc_next      = v + 32'd4;
        d.csr_wdata    = v;
        d.rd_addr      = rd;
        c.rd_wrb_sel   = sel;
        c.rd_wr_req    = req;
        c.ld_op        = ld;
        c.csr_op       = cop;
        c.csr_addr     = caddr;
        tbl_data[n_rows] = d;
        tbl_ctrl[n_rows] = c;
        tbl_dmem[n_rows] = dmem;
        tbl_rs1[n_rows]  = rs1;
        tbl_rs2[n_rows]  = rs2;
        n_rows++;
    endtask

    // Random rows stay legal with aligned loads only and no write to minstret
    task automatic add_random_rows(input int count);
        rd_wrb_sel_e sel;
        ld_op_e      ld;
        csr_op_e     cop;
        csr_addr_t   caddr;
        word_t       v;
        reg_addr_t   rd;
        for (int k = 0; k < count; k++) begin
            sel   = rd_wrb_sel_e'(3'($unsigned($random(seed)) % 5));
            v     = $random(seed);
            rd    = 5'($random(seed));
            ld    = LD_NONE;
            cop   = CSR_NONE;
            caddr = CSR_MSCRATCH;
            if (sel == RD_WRB_DMEM) begin
                ld = ld_op_e'(3'(1 + $unsigned($random(seed)) % 5));
                if (ld == LD_W) begin
                    v[1:0] = 2'b00;
                end else if (ld == LD_H || ld == LD_HU) begin
                    v[0] = 1'b0;
                end
            end else if (sel == RD_WRB_CSR) begin
                caddr = v[4] ? CSR_MINSTRET : CSR_MSCRATCH;
                cop   = (v[5] && caddr == CSR_MSCRATCH) ? CSR_WRITE : CSR_READ;
            end
            add_row(sel, 1'b1, ld, cop, caddr, v, rd, $random(seed), rd, 5'($random(seed)));
        end
    endtask

    task automatic build_table();
        // Columns are select, write req, load op, CSR op, CSR addr, value, rd, dmem, rs1, rs2
        add_row(RD_WRB_ALU,    1, LD_NONE, CSR_NONE, 12'h0, 32'h1234_5678, 1, 0, 1, 1);
        add_row(RD_WRB_ALU,    1, LD_NONE, CSR_NONE, 12'h0, 32'h0bad_f00d, 2, 0, 1, 2);
        add_row(RD_WRB_INC_PC, 1, LD_NONE, CSR_NONE, 12'h0, 32'h0000_1000, 3, 0, 3, 2);
        add_row(RD_WRB_M_ALU,  1, LD_NONE, CSR_NONE, 12'h0, 32'hdead_beef, 4, 0, 4, 3);
        // Loads at every legal offset
        add_row(RD_WRB_DMEM, 1, LD_W,  CSR_NONE, 12'h0, 32'h2000, 5, 32'h8765_4321, 5, 4);
        add_row(RD_WRB_DMEM, 1, LD_B,  CSR_NONE, 12'h0, 32'h2000, 6, 32'h1234_5680, 6, 5);
        add_row(RD_WRB_DMEM, 1, LD_B,  CSR_NONE, 12'h0, 32'h2001, 6, 32'h0000_7f00, 6, 6);
        add_row(RD_WRB_DMEM, 1, LD_B,  CSR_NONE, 12'h0, 32'h2002, 6, 32'h00a5_0000, 6, 6);
        add_row(RD_WRB_DMEM, 1, LD_B,  CSR_NONE, 12'h0, 32'h2003, 6, 32'hc300_0000, 6, 6);
        add_row(RD_WRB_DMEM, 1, LD_BU, CSR_NONE, 12'h0, 32'h2003, 7, 32'hc300_0000, 7, 6);
        add_row(RD_WRB_DMEM, 1, LD_BU, CSR_NONE, 12'h0, 32'h2005, 7, 32'h0000_9900, 7, 7);
        add_row(RD_WRB_DMEM, 1, LD_BU, CSR_NONE, 12'h0, 32'h2004, 7, 32'h0000_00fe, 7, 7);
        add_row(RD_WRB_DMEM, 1, LD_BU, CSR_NONE, 12'h0, 32'h2006, 7, 32'h0081_0000, 7, 7);
        add_row(RD_WRB_DMEM, 1, LD_H,  CSR_NONE, 12'h0, 32'h2008, 8, 32'h0000_8001, 8, 7);
        add_row(RD_WRB_DMEM, 1, LD_H,  CSR_NONE, 12'h0, 32'h200a, 8, 32'h7ffe_0000, 8, 8);
        add_row(RD_WRB_DMEM, 1, LD_HU, CSR_NONE, 12'h0, 32'h200e, 9, 32'hf00f_0000, 9, 8);
        add_row(RD_WRB_DMEM, 1, LD_HU, CSR_NONE, 12'h0, 32'h200c, 9, 32'h0000_beef, 9, 9);
        // x0 stays zero even in the forwarding cycle
        add_row(RD_WRB_ALU, 1, LD_NONE, CSR_NONE, 12'h0, 32'hffff_ffff, 0, 0, 0, 0);
        add_row(RD_WRB_ALU, 0, LD_NONE, CSR_NONE, 12'h0, 32'h0, 0, 0, 0, 5);
        // CSR reads and writes
        add_row(RD_WRB_CSR, 1, LD_NONE, CSR_READ,  CSR_MSCRATCH, 32'h0, 10, 0, 10, 0);
        add_row(RD_WRB_CSR, 1, LD_NONE, CSR_WRITE, CSR_MSCRATCH, 32'hcafe_babe, 11, 0, 11, 10);
        add_row(RD_WRB_CSR, 1, LD_NONE, CSR_WRITE, CSR_MSCRATCH, 32'h1357_9bdf, 12, 0, 11, 12);
        add_row(RD_WRB_CSR, 1, LD_NONE, CSR_READ,  CSR_MSCRATCH, 32'h0, 13, 0, 13, 12);
        add_row(RD_WRB_CSR, 1, LD_NONE, CSR_READ,  CSR_MINSTRET, 32'h0, 14, 0, 14, 13);
        add_row(RD_WRB_ALU, 0, LD_NONE, CSR_WRITE, CSR_MSCRATCH, 32'h0000_0042, 1, 0, 14, 1);
        add_row(RD_WRB_CSR, 1, LD_NONE, CSR_READ,  CSR_MSCRATCH, 32'h0, 15, 0, 15, 6);
        add_random_rows(N_RANDOM);
    endtask

    // Byte or halfword lane picked by the low address bits and then extended
    function automatic word_t load_value(input ld_op_e ld, input word_t addr, input word_t mem);
        logic [7:0]  b;
        logic [15:0] h;
        b = mem[{addr[1:0], 3'b000} +: 8];
        h = addr[1] ? mem[31:16] : mem[15:0];
        case (ld)
            LD_B:    return {{24{b[7]}}, b};
            LD_H:    return {{16{h[15]}}, h};
            LD_W:    return mem;
            LD_BU:   return {24'h0, b};
            LD_HU:   return {16'h0, h};
            default: return '0;
        endcase
    endfunction

    function automatic word_t expected_operand(input reg_addr_t a);
        if (a == 0) begin
            return '0;
        end
        if (wb_req && wb_addr == a) begin
            return wb_data;
        end
        return shadow_regs[a];
    endfunction

    // Advances the model across the rising edge that takes row i
    task automatic model_edge(input int i);
        exe2lsu_data_s d;
        exe2lsu_ctrl_s c;
        word_t         csr_old;
        d       = tbl_data[i];
        c       = tbl_ctrl[i];
        csr_old = '0;
        if (c.csr_op == CSR_READ || c.csr_op == CSR_WRITE) begin
            if (c.csr_addr == CSR_MSCRATCH) begin
                csr_old = mscratch_m;
            end else if (c.csr_addr == CSR_MINSTRET) begin
                csr_old = minstret_m;
            end
        end
        if (c.csr_op == CSR_WRITE && c.csr_addr == CSR_MSCRATCH) begin
            mscratch_m = d.csr_wdata;
        end
        // The instruction leaving writeback retires now
        if (wb_req && wb_addr != 0) begin
            shadow_regs[wb_addr] = wb_data;
            minstret_m = minstret_m + 1;
        end
        case (c.rd_wrb_sel)
            RD_WRB_ALU:    wb_data = d.alu_result;
            RD_WRB_INC_PC: wb_data = d.pc_next;
            RD_WRB_DMEM:   wb_data = load_value(c.ld_op, d.alu_result, tbl_dmem[i]);
            RD_WRB_CSR:    wb_data = csr_old;
            RD_WRB_M_ALU:  wb_data = d.alu_m_result;
            default:       wb_data = '0;
        endcase
        wb_addr = d.rd_addr;
        wb_req  = c.rd_wr_req;
    endtask

    task automatic compare_value(input int row, input string name, input word_t got,
                                 input word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED row %0d %s: got %h, expected %h", row, name, got, exp);
        end
    endtask

    task automatic check_outputs(input int i);
        compare_value(i, "wrb2id_fb_o.rd_data", wrb_fb.rd_data, wb_data);
        compare_value(i, "wrb2id_fb_o.rd_addr", 32'(wrb_fb.rd_addr), 32'(wb_addr));
        compare_value(i, "wrb2id_fb_o.rd_wr_req", 32'(wrb_fb.rd_wr_req), 32'(wb_req));
        compare_value(i, "rs1_data_o", rs1_data, expected_operand(tbl_rs1[i]));
        compare_value(i, "rs2_data_o", rs2_data, expected_operand(tbl_rs2[i]));
    endtask

    initial begin
        arst_n     = 1'b0;
        exe_data   = '0;
        exe_ctrl   = '0;
        dmem_rdata = '0;
        rs1_addr   = '0;
        rs2_addr   = '0;
        seed       = 32'hef55_8736;
        mscratch_m = '0;
        minstret_m = '0;
        wb_data    = '0;
        wb_addr    = '0;
        wb_req     = 1'b0;
        for (int r = 0; r < 32; r++) begin
            shadow_regs[r] = '0;
        end
        build_table();

        repeat (5) @(negedge clk);
        arst_n = 1'b1;

        // Nothing retires right after reset
        compare_value(-1, "wrb2id_fb_o.rd_wr_req", 32'(wrb_fb.rd_wr_req), 32'h0);

        // Every register reads zero with one address pair per cycle
        for (int a = 0; a < 16; a++) begin
            rs1_addr = 5'(a);
            rs2_addr = 5'(a + 16);
            @(negedge clk);
            compare_value(-1, "rs1_data_o", rs1_data, 32'h0);
            compare_value(-1, "rs2_data_o", rs2_data, 32'h0);
        end

        rows_started = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            exe_data   = tbl_data[i];
            exe_ctrl   = tbl_ctrl[i];
            dmem_rdata = tbl_dmem[i];
            rs1_addr   = tbl_rs1[i];
            rs2_addr   = tbl_rs2[i];
            model_edge(i);
            @(negedge clk);
            check_outputs(i);
        end

        $display("Rows: %0d, checks: %0d, errors: %0d", n_rows, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : tb_core_backend

`default_nettype wire

//--- src.f
source/pcore_pkg.sv
source/lsu_stage.sv
source/csr_unit.sv
source/writeback.sv
source/reg_file.sv
source/operand_fwd.sv
source/core_backend.sv
tb/tb_core_backend.sv
